//--- src/mem_mux_cfg.svh
`ifndef MEM_MUX_CFG_SVH
`define MEM_MUX_CFG_SVH

// Memory port widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 64

// Requester side
`define SRC_TAG_WIDTH 8
`define NUM_SRCS 3
`define SRC_ID_WIDTH 2

// Source tag plus source number
`define MEM_TAG_WIDTH 10

// Bit 0 stays the non-cacheable flag
`define TAG_SEL_IDX 1

`define MEM_FIFO_DEPTH 4

`endif

//--- src/mem_mux_pkg.sv
`include "mem_mux_cfg.svh"

package mem_mux_pkg;

    typedef logic [`SRC_ID_WIDTH-1:0] src_id_t;

    typedef logic [`SRC_TAG_WIDTH-1:0] src_tag_t;

    typedef logic [`MEM_TAG_WIDTH-1:0] mem_tag_t;

    // Outgoing request, rw high for writes
    typedef struct packed {
        logic                       rw;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_DATA_WIDTH-1:0] data;
        mem_tag_t                   tag;
    } mem_req_t;

    // Read response from memory
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0] data;
        mem_tag_t                   tag;
    } mem_rsp_t;

endpackage

//--- src/mem_req_arbiter.sv
`timescale 1ns/1ns

`include "mem_mux_cfg.svh"

module mem_req_arbiter import mem_mux_pkg::*; (
    input  logic                                         clk,
    input  logic                                         rst,

    input  logic [`NUM_SRCS-1:0]                         src_req_valid,
    input  logic [`NUM_SRCS-1:0]                         src_req_rw,
    input  logic [`NUM_SRCS-1:0][`MEM_ADDR_WIDTH-1:0]    src_req_addr,
    input  logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0]    src_req_data,
    input  src_tag_t [`NUM_SRCS-1:0]                     src_req_tag,
    output logic [`NUM_SRCS-1:0]                         src_req_ready,

    output logic                                         out_valid,
    output mem_req_t                                     out_req,
    input  logic                                         out_ready
);

    src_id_t  rr_ptr;
    src_id_t  grant_id;
    logic     grant_found;
    src_tag_t grant_tag;

    // Search starts at the round-robin pointer
    always_comb begin
        int unsigned idx;
        grant_found = 1'b0;
        grant_id    = rr_ptr;
        for (int i = 0; i < `NUM_SRCS; i++) begin
            idx = (int'(rr_ptr) + i) % `NUM_SRCS;
            if (!grant_found && src_req_valid[idx]) begin
                grant_found = 1'b1;
                grant_id    = src_id_t'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_SRCS; i++) begin
            src_req_ready[i] = out_ready && grant_found && (grant_id == src_id_t'(i));
        end
    end

    assign out_valid = grant_found;
    assign grant_tag = src_req_tag[grant_id];

    always_comb begin
        out_req.rw   = src_req_rw[grant_id];
        out_req.addr = src_req_addr[grant_id];
        out_req.data = src_req_data[grant_id];
        // Source number goes in above the NC flag
        out_req.tag  = {grant_tag[`SRC_TAG_WIDTH-1:`TAG_SEL_IDX],
                        grant_id,
                        grant_tag[`TAG_SEL_IDX-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rr_ptr <= (grant_id == src_id_t'(`NUM_SRCS - 1)) ? '0 : grant_id + 1'b1;
        end
    end

    // No source wins twice in a row while another one waits
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready && ((src_req_valid & ~src_req_ready) != '0))
        |=> (grant_id != $past(grant_id)))
        else $error("arbiter granted the same source twice while another waited");

endmodule

//--- src/mem_fifo.sv
`timescale 1ns/1ns

`include "mem_mux_cfg.svh"

module mem_fifo import mem_mux_pkg::*; #(
    parameter type payload_t = mem_req_t
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,

    output logic     not_empty
);

    localparam int DEPTH = `MEM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign not_empty = out_valid;
    // Full buffer still takes a push alongside a pop
    assign in_ready  = !full || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH))
        else $error("buffer count went past its depth");

    a_empty_ptrs: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |-> (wr_ptr == rd_ptr))
        else $error("pointers disagree on an empty buffer");

endmodule

//--- src/mem_rsp_router.sv
`timescale 1ns/1ns

`include "mem_mux_cfg.svh"

module mem_rsp_router import mem_mux_pkg::*; (
    input  logic                                         clk,
    input  logic                                         rst,

    input  logic                                         in_valid,
    input  mem_rsp_t                                     in_rsp,
    output logic                                         in_ready,

    output logic [`NUM_SRCS-1:0]                         src_rsp_valid,
    output logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0]    src_rsp_data,
    output src_tag_t [`NUM_SRCS-1:0]                     src_rsp_tag,
    input  logic [`NUM_SRCS-1:0]                         src_rsp_ready
);

    src_id_t              rsp_id;
    src_tag_t             rsp_tag;
    logic [`NUM_SRCS-1:0] sel;

    assign rsp_id = in_rsp.tag[`TAG_SEL_IDX +: `SRC_ID_WIDTH];

    // Drop the source number, close the gap
    assign rsp_tag = {in_rsp.tag[`MEM_TAG_WIDTH-1:`TAG_SEL_IDX+`SRC_ID_WIDTH],
                      in_rsp.tag[`TAG_SEL_IDX-1:0]};

    always_comb begin
        for (int i = 0; i < `NUM_SRCS; i++) begin
            sel[i]           = (rsp_id == src_id_t'(i));
            src_rsp_valid[i] = in_valid && sel[i];
            src_rsp_data[i]  = in_rsp.data;
            src_rsp_tag[i]   = rsp_tag;
        end
    end

    // Stalled target holds the response buffer
    assign in_ready = |(sel & src_rsp_ready);

    // Memory must hand back a tag that the arbiter built
    a_valid_src: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (int'(rsp_id) < `NUM_SRCS))
        else $error("response tag carries unknown source %0d", rsp_id);

endmodule

//--- src/mem_cluster_mux.sv
`timescale 1ns/1ns

`include "mem_mux_cfg.svh"

module mem_cluster_mux import mem_mux_pkg::*; (
    input  logic                                         clk,
    input  logic                                         rst,

    // Requesters
    input  logic [`NUM_SRCS-1:0]                         src_req_valid,
    input  logic [`NUM_SRCS-1:0]                         src_req_rw,
    input  logic [`NUM_SRCS-1:0][`MEM_ADDR_WIDTH-1:0]    src_req_addr,
    input  logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0]    src_req_data,
    input  src_tag_t [`NUM_SRCS-1:0]                     src_req_tag,
    output logic [`NUM_SRCS-1:0]                         src_req_ready,

    output logic [`NUM_SRCS-1:0]                         src_rsp_valid,
    output logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0]    src_rsp_data,
    output src_tag_t [`NUM_SRCS-1:0]                     src_rsp_tag,
    input  logic [`NUM_SRCS-1:0]                         src_rsp_ready,

    // Memory
    output logic                                         mem_req_valid,
    output mem_req_t                                     mem_req,
    input  logic                                         mem_req_ready,

    input  logic                                         mem_rsp_valid,
    input  mem_rsp_t                                     mem_rsp,
    output logic                                         mem_rsp_ready,

    output logic                                         busy
);

    logic     arb_valid;
    mem_req_t arb_req;
    logic     arb_ready;
    logic     req_not_empty;

    logic     rtr_valid;
    mem_rsp_t rtr_rsp;
    logic     rtr_ready;
    logic     rsp_not_empty;

    mem_req_arbiter arb0 (
        .clk           (clk),
        .rst           (rst),
        .src_req_valid (src_req_valid),
        .src_req_rw    (src_req_rw),
        .src_req_addr  (src_req_addr),
        .src_req_data  (src_req_data),
        .src_req_tag   (src_req_tag),
        .src_req_ready (src_req_ready),
        .out_valid     (arb_valid),
        .out_req       (arb_req),
        .out_ready     (arb_ready)
    );

    mem_fifo #(
        .payload_t (mem_req_t)
    ) req_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_valid),
        .in_data   (arb_req),
        .in_ready  (arb_ready),
        .out_valid (mem_req_valid),
        .out_data  (mem_req),
        .out_ready (mem_req_ready),
        .not_empty (req_not_empty)
    );

    mem_fifo #(
        .payload_t (mem_rsp_t)
    ) rsp_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mem_rsp_valid),
        .in_data   (mem_rsp),
        .in_ready  (mem_rsp_ready),
        .out_valid (rtr_valid),
        .out_data  (rtr_rsp),
        .out_ready (rtr_ready),
        .not_empty (rsp_not_empty)
    );

    mem_rsp_router rtr0 (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (rtr_valid),
        .in_rsp        (rtr_rsp),
        .in_ready      (rtr_ready),
        .src_rsp_valid (src_rsp_valid),
        .src_rsp_data  (src_rsp_data),
        .src_rsp_tag   (src_rsp_tag),
        .src_rsp_ready (src_rsp_ready)
    );

    // Outstanding reads in memory do not count
    assign busy = req_not_empty | rsp_not_empty;

endmodule

//--- bench/tb_mem_cluster_mux.sv
`timescale 1ns/1ns

`include "mem_mux_cfg.svh"

module tb_mem_cluster_mux import mem_mux_pkg::*; ();

    typedef struct packed {
        logic [`NUM_SRCS-1:0]                      mask;
        logic [`NUM_SRCS-1:0]                      rw;
        logic [`NUM_SRCS-1:0][`MEM_ADDR_WIDTH-1:0] addr;
        logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0] data;
        src_tag_t [`NUM_SRCS-1:0]                  tag;
        logic [15:0]                               order;
        logic [15:0]                               ans;
        logic                                      stall;
    } step_t;

    logic                                      clk;
    logic                                      rst;
    logic [`NUM_SRCS-1:0]                      src_req_valid;
    logic [`NUM_SRCS-1:0]                      src_req_rw;
    logic [`NUM_SRCS-1:0][`MEM_ADDR_WIDTH-1:0] src_req_addr;
    logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0] src_req_data;
    src_tag_t [`NUM_SRCS-1:0]                  src_req_tag;
    logic [`NUM_SRCS-1:0]                      src_req_ready;
    logic [`NUM_SRCS-1:0]                      src_rsp_valid;
    logic [`NUM_SRCS-1:0][`MEM_DATA_WIDTH-1:0] src_rsp_data;
    src_tag_t [`NUM_SRCS-1:0]                  src_rsp_tag;
    logic [`NUM_SRCS-1:0]                      src_rsp_ready;
    logic                                      mem_req_valid;
    mem_req_t                                  mem_req;
    logic                                      mem_req_ready;
    logic                                      mem_rsp_valid;
    mem_rsp_t                                  mem_rsp;
    logic                                      mem_rsp_ready;
    logic                                      busy;

    string names[$];
    step_t steps[$];
    int    seed;
    int    cycles;
    int    cycle_limit;

    mem_cluster_mux dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_req(string name, mem_req_t exp, mem_req_t act);
        if (act !== exp) begin
            $display("error: test %s request expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_rsp(string name, mem_rsp_t exp, mem_rsp_t act);
        if (act !== exp) begin
            $display("error: test %s response expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("error: test %s flag expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run took more than %0d cycles", cycle_limit);
            fail_run();
        end
    endtask

    // Skips comment and blank lines by their field count
    task automatic load_stim();
        int          fd;
        string       line;
        string       name;
        logic [63:0] v[16];
        step_t       st;
        fd = $fopen("bench/mem_mux_stim.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file could not be opened");
            fail_run();
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15]) == 17) begin
                st.mask = v[0][`NUM_SRCS-1:0];
                for (int i = 0; i < `NUM_SRCS; i++) begin
                    st.rw[i]   = v[1 + 4 * i][0];
                    st.addr[i] = v[2 + 4 * i][`MEM_ADDR_WIDTH-1:0];
                    st.data[i] = v[3 + 4 * i];
                    st.tag[i]  = v[4 + 4 * i][`SRC_TAG_WIDTH-1:0];
                end
                st.order = v[13][15:0];
                st.ans   = v[14][15:0];
                st.stall = v[15][0];
                names.push_back(name);
                steps.push_back(st);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(int k);
        int                   nreq;
        int                   nrd;
        int                   req_got;
        int                   rsp_sent;
        int                   rsp_got;
        int                   held;
        int                   s;
        int                   idx;
        logic                 rsp_on;
        logic [`NUM_SRCS-1:0] req_pend;
        logic [`NUM_SRCS-1:0] rsp_pend;
        step_t                st;
        mem_req_t             exp_req;
        mem_rsp_t             exp_rsp;
        mem_rsp_t             got_rsp;
        mem_tag_t             rd_tag[$];
        src_id_t              rd_src[$];
        st = steps[k];
        nreq = 0;
        nrd = 0;
        req_got = 0;
        rsp_sent = 0;
        rsp_got = 0;
        held = 0;
        rsp_on = 1'b0;
        req_pend = st.mask;
        rsp_pend = st.mask & ~st.rw;
        for (int i = 0; i < `NUM_SRCS; i++) begin
            nreq += int'(req_pend[i]);
            nrd += int'(rsp_pend[i]);
        end
        src_req_rw <= st.rw;
        src_req_addr <= st.addr;
        src_req_data <= st.data;
        src_req_tag <= st.tag;
        src_req_valid <= req_pend;
        while (req_got < nreq || rsp_got < nrd) begin
            tick();
            // Entries sitting in either buffer after the previous edge
            check_flag(names[k], held != 0, busy);
            for (int i = 0; i < `NUM_SRCS; i++) begin
                if (src_req_valid[i] && src_req_ready[i]) begin
                    req_pend[i] = 1'b0;
                    held++;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (req_got >= nreq) begin
                    $display("memory saw more requests than test %s sent", names[k]);
                    fail_run();
                end
                s = int'(st.order[4 * req_got +: 4]);
                exp_req.rw = st.rw[s];
                exp_req.addr = st.addr[s];
                exp_req.data = st.data[s];
                // NC flag, then source number, then the upper tag bits
                exp_req.tag = {st.tag[s][`SRC_TAG_WIDTH-1:1], src_id_t'(s), st.tag[s][0]};
                check_req(names[k], exp_req, mem_req);
                if (!mem_req.rw) begin
                    rd_tag.push_back(mem_req.tag);
                    rd_src.push_back(src_id_t'(s));
                end
                req_got++;
                held--;
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_on = 1'b0;
                rsp_sent++;
                held++;
            end
            for (int i = 0; i < `NUM_SRCS; i++) begin
                if (src_rsp_valid[i] && !rsp_pend[i]) begin
                    $display("unexpected response at source %0d in test %s", i, names[k]);
                    fail_run();
                end
                if (src_rsp_valid[i] && src_rsp_ready[i]) begin
                    exp_rsp.data = 64'(st.addr[i]) + 64'(i);
                    exp_rsp.tag = {src_id_t'(i), st.tag[i]};
                    got_rsp.data = src_rsp_data[i];
                    got_rsp.tag = {src_id_t'(i), src_rsp_tag[i]};
                    check_rsp(names[k], exp_rsp, got_rsp);
                    rsp_pend[i] = 1'b0;
                    rsp_got++;
                    held--;
                end
            end
            // Model answers once every request of the step has arrived
            if (!rsp_on && req_got == nreq && rsp_sent < nrd) begin
                idx = int'(st.ans[4 * rsp_sent +: 4]);
                mem_rsp.data <= 64'(st.addr[rd_src[idx]]) + 64'(rd_src[idx]);
                mem_rsp.tag <= rd_tag[idx];
                rsp_on = 1'b1;
            end
            mem_rsp_valid <= rsp_on;
            src_req_valid <= req_pend;
            mem_req_ready <= st.stall ? (($random(seed) & 3) != 0) : 1'b1;
            src_rsp_ready <= st.stall ? `NUM_SRCS'($random(seed)) : '1;
        end
        tick();
        check_flag(names[k], 1'b0, busy);
    endtask

    initial begin
        seed = 32'h59166b9d;
        cycles = 0;
        rst = 1'b1;
        src_req_valid = '0;
        src_req_rw = '0;
        src_req_addr = '0;
        src_req_data = '0;
        src_req_tag = '0;
        src_rsp_ready = '1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        load_stim();
        cycle_limit = 40 * steps.size();
        if (steps.size() == 0) begin
            $display("the stimulus file holds no test steps");
            fail_run();
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        tick();
        check_flag("reset", 1'b0, busy);
        check_flag("reset", 1'b0, mem_req_valid);
        check_flag("reset", 1'b0, |src_rsp_valid);
        for (int k = 0; k < steps.size(); k++) begin
            run_step(k);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- bench/mem_mux_stim.txt
# name mask, then rw addr data tag for sources 0 1 2, then order ans stall (all hex)
# order lists sources at memory, ans lists read indexes answered, first entry in low digit
rr_first     7  0 1000 0 10  0 1104 0 21  0 1208 0 32  210 012 0
rr_second    7  0 1010 0 44  0 1114 0 55  0 1218 0 66  210 210 0
single_read  2  0 0 0 00  0 2000 0 7f  0 0 0 00  1 0 0
single_write 1  1 3000 1234abcd 03  0 0 0 00  0 0 0 00  0 0 0
mixed        7  1 4000 cafe 0a  0 4104 0 0b  0 4208 0 0c  021 01 0
stall_reads  7  0 5000 0 81  0 5104 0 92  0 5208 0 a3  021 120 1
stall_mixed  5  0 6000 0 c4  0 0 0 00  1 6208 beef d5  02 0 1
stall_pair   6  0 0 0 00  0 7104 0 e6  0 7208 0 f7  21 01 1
tag_edges    7  0 fffffffc 0 ff  0 0 0 00  0 ffffffff 0 01  210 102 1
write_all    7  1 8000 11 12  1 8104 22 23  1 8208 33 34  210 0 1

//--- flist.f
+incdir+src
src/mem_mux_pkg.sv
src/mem_req_arbiter.sv
src/mem_fifo.sv
src/mem_rsp_router.sv
src/mem_cluster_mux.sv
bench/tb_mem_cluster_mux.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the mux testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

top=tb_mem_cluster_mux
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
    exit 0
fi
echo "pass line missing from $log"
exit 1
